// File: rtl/vram_pkg.sv
package vram_pkg;

    // tile map region
    localparam int TILE_DEPTH = 64;
    localparam int TILE_AW    = 6;

    // palette region
    localparam int PAL_DEPTH  = 16;
    localparam int PAL_AW     = 4;

    // CPU and PPU data bus width
    localparam int CPU_WORD_W = 16;

    // one tile map entry, packed to a bus word
    typedef struct packed {
        logic [9:0] tile_idx;   // pattern number
        logic [3:0] pal_sel;    // palette line
        logic       hflip;
        logic       vflip;
    } tile_entry_t;

    // 15-bit colour, msb unused
    typedef struct packed {
        logic       pad;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } pal_color_t;

    // target of a CPU write or a PPU read
    typedef enum logic {
        REGION_TILE = 1'b0,
        REGION_PAL  = 1'b1
    } vram_region_e;

endpackage : vram_pkg

// File: rtl/vram_if.sv
`timescale 1ns/1ps

// one copy channel between a bank and its copier
// addresses cover one half of the region, the bank adds the half bit
interface vram_if
    import vram_pkg::*;
#(
    parameter type data_t = logic [CPU_WORD_W-1:0],
    parameter int  AW     = 5
) ();

    logic [AW-1:0] addr_c;     // read address into the CPU copy
    data_t         rddata_c;   // read data, one cycle after addr_c
    logic [AW-1:0] addr_p;     // write address into the PPU copy
    data_t         wrdata_p;
    logic          wren_p;

    modport bank (
        input  addr_c,
        input  addr_p,
        input  wrdata_p,
        input  wren_p,
        output rddata_c
    );

    modport copier (
        output addr_c,
        output addr_p,
        output wrdata_p,
        output wren_p,
        input  rddata_c
    );

endinterface : vram_if

// File: rtl/vram_dp_ram.sv
`timescale 1ns/1ps

// true dual-port RAM, synchronous read and write on both ports
module vram_dp_ram
    import vram_pkg::*;
#(
    parameter type data_t = logic [CPU_WORD_W-1:0],
    parameter int  AW     = TILE_AW
) (
    input  logic          clk,

    input  logic [AW-1:0] addr_a,
    input  data_t         wrdata_a,
    input  logic          wren_a,
    output data_t         rddata_a,

    input  logic [AW-1:0] addr_b,
    input  data_t         wrdata_b,
    input  logic          wren_b,
    output data_t         rddata_b
);

    data_t mem [2**AW];   // no reset, contents unknown until written

    // a write on both ports to one address is undefined
    always_ff @(posedge clk) begin
        if (wren_a) begin
            mem[addr_a] <= wrdata_a;
        end
        if (wren_b) begin
            mem[addr_b] <= wrdata_b;
        end
        rddata_a <= mem[addr_a];   // old data on read-during-write
        rddata_b <= mem[addr_b];
    end

endmodule : vram_dp_ram

// File: rtl/region_copier.sv
`timescale 1ns/1ps

// walks one half of a region: reads the CPU copy, writes the PPU copy
// read of address k+1 overlaps the write of address k
module region_copier
    import vram_pkg::*;
#(
    parameter type data_t     = logic [CPU_WORD_W-1:0],
    parameter int  AW         = TILE_AW - 1,
    parameter int  HALF_DEPTH = TILE_DEPTH / 2
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,    // one-cycle launch strobe
    output logic   finish,   // pulses with the last write
    vram_if.copier chan
);

    logic          run;      // read phase active
    logic [AW-1:0] addr;
    logic          vld_d;    // read issued last cycle
    logic [AW-1:0] addr_d;
    logic          last;

    assign last = (addr == AW'(HALF_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run    <= 1'b0;
            addr   <= '0;
            vld_d  <= 1'b0;
            addr_d <= '0;
        end else begin
            if (start && !run) begin
                run  <= 1'b1;
                addr <= '0;
            end else if (run) begin
                if (last) begin
                    run <= 1'b0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
            // delay line turns the read into the write
            vld_d  <= run;
            addr_d <= addr;
        end
    end

    assign chan.addr_c   = addr;
    assign chan.addr_p   = addr_d;
    assign chan.wrdata_p = chan.rddata_c;   // RAM data arrives with vld_d
    assign chan.wren_p   = vld_d;

    assign finish = vld_d && (addr_d == AW'(HALF_DEPTH - 1));

endmodule : region_copier

// File: rtl/vram_bank.sv
`timescale 1ns/1ps

// one region: CPU-facing copy and PPU-facing copy
// idle: CPU writes port a of cpu_ram, PPU reads port a of ppu_ram
// copy: both ports of each RAM belong to the two copy channels
module vram_bank
    import vram_pkg::*;
#(
    parameter type data_t = logic [CPU_WORD_W-1:0],
    parameter int  AW     = TILE_AW
) (
    input  logic          clk,

    input  logic          cpu_wr,
    input  logic [AW-1:0] cpu_addr,
    input  data_t         cpu_wrdata,

    input  logic [AW-1:0] ppu_addr,
    output data_t         ppu_rddata,

    input  logic          copy_busy,
    vram_if.bank          chan_a,      // lower half
    vram_if.bank          chan_b       // upper half
);

    logic [AW-1:0] cram_addr_a;
    logic [AW-1:0] cram_addr_b;
    logic          cram_wren_a;
    data_t         cram_rd_a;
    data_t         cram_rd_b;

    logic [AW-1:0] pram_addr_a;
    logic [AW-1:0] pram_addr_b;
    logic          pram_wren_a;
    logic          pram_wren_b;
    data_t         pram_rd_a;

    // CPU copy, port a shared with the CPU, port b read only
    assign cram_addr_a = copy_busy ? {1'b0, chan_a.addr_c} : cpu_addr;
    assign cram_wren_a = cpu_wr && !copy_busy;   // writes during a copy are lost
    assign cram_addr_b = {1'b1, chan_b.addr_c};

    vram_dp_ram #(
        .data_t (data_t),
        .AW     (AW)
    ) cpu_ram (
        .clk,
        .addr_a   (cram_addr_a),
        .wrdata_a (cpu_wrdata),
        .wren_a   (cram_wren_a),
        .rddata_a (cram_rd_a),
        .addr_b   (cram_addr_b),
        .wrdata_b ('0),
        .wren_b   (1'b0),
        .rddata_b (cram_rd_b)
    );

    assign chan_a.rddata_c = cram_rd_a;
    assign chan_b.rddata_c = cram_rd_b;

    // PPU copy, port a shared with the PPU, port b copy write only
    assign pram_addr_a = copy_busy ? {1'b0, chan_a.addr_p} : ppu_addr;
    assign pram_wren_a = copy_busy && chan_a.wren_p;
    assign pram_addr_b = {1'b1, chan_b.addr_p};
    assign pram_wren_b = copy_busy && chan_b.wren_p;

    vram_dp_ram #(
        .data_t (data_t),
        .AW     (AW)
    ) ppu_ram (
        .clk,
        .addr_a   (pram_addr_a),
        .wrdata_a (chan_a.wrdata_p),
        .wren_a   (pram_wren_a),
        .rddata_a (pram_rd_a),
        .addr_b   (pram_addr_b),
        .wrdata_b (chan_b.wrdata_p),
        .wren_b   (pram_wren_b),
        .rddata_b ()
    );

    assign ppu_rddata = pram_rd_a;   // garbage while copy_busy

endmodule : vram_bank

// File: rtl/vram_sync_ctrl.sv
`timescale 1ns/1ps

// launches the four half-region copiers on sync, collects their finish
// strobes and pulses done once every copier has finished
module vram_sync_ctrl
    import vram_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sync,    // one-cycle strobe, ignored while busy
    output logic   done,
    output logic   busy,

    vram_if.copier tile_a,
    vram_if.copier tile_b,
    vram_if.copier pal_a,
    vram_if.copier pal_b
);

    typedef enum logic {
        IDLE,
        SYNC
    } state_t;

    state_t     state;
    logic       start;
    logic [3:0] fin;     // {pal_b, pal_a, tile_b, tile_a}
    logic [3:0] seen;    // finish strobes caught so far
    logic       all_seen;

    assign start    = (state == IDLE) && sync;
    assign all_seen = &seen;
    assign busy     = (state == SYNC);
    assign done     = (state == SYNC) && all_seen;

    region_copier #(
        .data_t     (tile_entry_t),
        .AW         (TILE_AW - 1),
        .HALF_DEPTH (TILE_DEPTH / 2)
    ) u_tile_a (
        .clk,
        .rst_n,
        .start,
        .finish (fin[0]),
        .chan   (tile_a)
    );

    region_copier #(
        .data_t     (tile_entry_t),
        .AW         (TILE_AW - 1),
        .HALF_DEPTH (TILE_DEPTH / 2)
    ) u_tile_b (
        .clk,
        .rst_n,
        .start,
        .finish (fin[1]),
        .chan   (tile_b)
    );

    region_copier #(
        .data_t     (pal_color_t),
        .AW         (PAL_AW - 1),
        .HALF_DEPTH (PAL_DEPTH / 2)
    ) u_pal_a (
        .clk,
        .rst_n,
        .start,
        .finish (fin[2]),
        .chan   (pal_a)
    );

    region_copier #(
        .data_t     (pal_color_t),
        .AW         (PAL_AW - 1),
        .HALF_DEPTH (PAL_DEPTH / 2)
    ) u_pal_b (
        .clk,
        .rst_n,
        .start,
        .finish (fin[3]),
        .chan   (pal_b)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            seen  <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (sync) begin
                        state <= SYNC;
                    end
                end
                SYNC: begin
                    seen <= seen | fin;   // palette halves finish long before tile
                    if (all_seen) begin
                        state <= IDLE;    // done pulses this cycle
                        seen  <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule : vram_sync_ctrl

// File: rtl/vram_sync_top.sv
`timescale 1ns/1ps

// double-buffered VRAM: tile map and palette, CPU side and PPU side
module vram_sync_top
    import vram_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  sync,
    output logic                  done,
    output logic                  busy,

    input  logic                  cpu_wr,
    input  vram_region_e          cpu_region,
    input  logic [TILE_AW-1:0]    cpu_addr,     // palette uses the low bits
    input  logic [CPU_WORD_W-1:0] cpu_wrdata,

    input  vram_region_e          ppu_region,
    input  logic [TILE_AW-1:0]    ppu_addr,
    output logic [CPU_WORD_W-1:0] ppu_rddata    // one cycle after ppu_addr
);

    logic         tile_wr;
    logic         pal_wr;
    tile_entry_t  tile_rd;
    pal_color_t   pal_rd;
    vram_region_e ppu_region_q;   // lines up with the RAM read latency

    vram_if #(.data_t(tile_entry_t), .AW(TILE_AW - 1)) tile_a ();
    vram_if #(.data_t(tile_entry_t), .AW(TILE_AW - 1)) tile_b ();
    vram_if #(.data_t(pal_color_t),  .AW(PAL_AW - 1))  pal_a ();
    vram_if #(.data_t(pal_color_t),  .AW(PAL_AW - 1))  pal_b ();

    assign tile_wr = cpu_wr && (cpu_region == REGION_TILE);
    assign pal_wr  = cpu_wr && (cpu_region == REGION_PAL);

    vram_sync_ctrl u_ctrl (
        .clk,
        .rst_n,
        .sync,
        .done,
        .busy,
        .tile_a,
        .tile_b,
        .pal_a,
        .pal_b
    );

    vram_bank #(
        .data_t (tile_entry_t),
        .AW     (TILE_AW)
    ) tile_bank (
        .clk,
        .cpu_wr     (tile_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wrdata (tile_entry_t'(cpu_wrdata)),
        .ppu_addr   (ppu_addr),
        .ppu_rddata (tile_rd),
        .copy_busy  (busy),
        .chan_a     (tile_a),
        .chan_b     (tile_b)
    );

    vram_bank #(
        .data_t (pal_color_t),
        .AW     (PAL_AW)
    ) pal_bank (
        .clk,
        .cpu_wr     (pal_wr),
        .cpu_addr   (cpu_addr[PAL_AW-1:0]),
        .cpu_wrdata (pal_color_t'(cpu_wrdata)),
        .ppu_addr   (ppu_addr[PAL_AW-1:0]),
        .ppu_rddata (pal_rd),
        .copy_busy  (busy),
        .chan_a     (pal_a),
        .chan_b     (pal_b)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppu_region_q <= REGION_TILE;
        end else begin
            ppu_region_q <= ppu_region;
        end
    end

    // read data mux
    always_comb begin
        unique case (ppu_region_q)
            REGION_PAL: ppu_rddata = pal_rd;
            default:    ppu_rddata = tile_rd;
        endcase
    end

endmodule : vram_sync_top

// File: verif/tb_vram_sync.sv
`timescale 1ns/1ps

module tb_vram_sync
    import vram_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic                  sync;
    logic                  done;
    logic                  busy;
    logic                  cpu_wr;
    vram_region_e          cpu_region;
    logic [TILE_AW-1:0]    cpu_addr;
    logic [CPU_WORD_W-1:0] cpu_wrdata;
    vram_region_e          ppu_region;
    logic [TILE_AW-1:0]    ppu_addr;
    logic [CPU_WORD_W-1:0] ppu_rddata;

    // shadow model, CPU side and PPU side of each region
    tile_entry_t tile_cpu [TILE_DEPTH];
    tile_entry_t tile_ppu [TILE_DEPTH];
    pal_color_t  pal_cpu  [PAL_DEPTH];
    pal_color_t  pal_ppu  [PAL_DEPTH];

    int errors;
    int seed;

    vram_sync_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sync       (sync),
        .done       (done),
        .busy       (busy),
        .cpu_wr     (cpu_wr),
        .cpu_region (cpu_region),
        .cpu_addr   (cpu_addr),
        .cpu_wrdata (cpu_wrdata),
        .ppu_region (ppu_region),
        .ppu_addr   (ppu_addr),
        .ppu_rddata (ppu_rddata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ends a run that stops making progress
    initial begin : watchdog
        int limit;
        limit = 6 * 40 + 600 * 2 + 200;   // 6 syncs, 600 accesses
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_tile(input string name, input tile_entry_t exp, input tile_entry_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pal(input string name, input pal_color_t exp, input pal_color_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] t=%0t done latency expected %0d got %0d", $time, exp, act);
            errors++;
        end
    endtask

    // word depends on every address bit
    function automatic logic [15:0] pattern_word(input int addr, input logic [3:0] salt);
        return {salt, addr[5:0], ~addr[5:0]};
    endfunction

    // all tasks start and end just after a falling edge
    task automatic cpu_write(input vram_region_e region, input int addr, input logic [15:0] data);
        cpu_wr     = 1'b1;
        cpu_region = region;
        cpu_addr   = addr[5:0];
        cpu_wrdata = data;
        @(negedge clk);
        cpu_wr = 1'b0;
        if (region == REGION_TILE) begin
            tile_cpu[addr] = data;
        end else begin
            pal_cpu[addr] = data;
        end
    endtask

    task automatic do_sync();
        int cycles;
        bit seen_done;
        cycles    = 0;
        seen_done = 1'b0;
        sync      = 1'b1;
        while (!seen_done && cycles < 60) begin
            @(negedge clk);
            sync = 1'b0;
            cycles++;
            check_bit("busy", 1'b1, busy);   // high up to and including done
            if (done === 1'b1) begin
                seen_done = 1'b1;
            end
        end
        if (!seen_done) begin
            $display("ERROR: done did not pulse within 60 cycles of sync");
            errors++;
        end else begin
            check_latency(TILE_DEPTH / 2 + 2, cycles);
        end
        @(negedge clk);
        check_bit("done", 1'b0, done);   // single-cycle strobe
        check_bit("busy", 1'b0, busy);
        tile_ppu = tile_cpu;
        pal_ppu  = pal_cpu;
    endtask

    task automatic read_all_check();
        tile_entry_t t;
        pal_color_t  p;
        for (int a = 0; a < TILE_DEPTH; a++) begin
            ppu_region = REGION_TILE;
            ppu_addr   = a[5:0];
            @(negedge clk);
            t = ppu_rddata;
            check_tile($sformatf("ppu_rddata tile[%0d]", a), tile_ppu[a], t);
        end
        for (int a = 0; a < PAL_DEPTH; a++) begin
            ppu_region = REGION_PAL;
            ppu_addr   = a[5:0];
            @(negedge clk);
            p = ppu_rddata;
            check_pal($sformatf("ppu_rddata pal[%0d]", a), pal_ppu[a], p);
        end
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("busy", 1'b0, busy);
        end
    endtask

    task automatic fill_and_sync();
        for (int a = 0; a < TILE_DEPTH; a++) begin
            cpu_write(REGION_TILE, a, pattern_word(a, 4'h1));
        end
        for (int a = 0; a < PAL_DEPTH; a++) begin
            cpu_write(REGION_PAL, a, pattern_word(a, 4'h9));
        end
        do_sync();
    endtask

    task automatic overwrite_without_sync();
        cpu_write(REGION_TILE, 0, pattern_word(0, 4'h2));
        cpu_write(REGION_TILE, 17, pattern_word(17, 4'h2));
        cpu_write(REGION_TILE, 40, pattern_word(40, 4'h2));
        cpu_write(REGION_TILE, 63, pattern_word(63, 4'h2));
        cpu_write(REGION_PAL, 2, pattern_word(2, 4'h3));
        cpu_write(REGION_PAL, 9, pattern_word(9, 4'h3));
        read_all_check();   // PPU side unchanged until sync
        do_sync();
        read_all_check();
    endtask

    task automatic sync_during_copy();
        int          done_count;
        logic [15:0] lost;
        lost       = ~tile_cpu[3];   // never reaches the model
        done_count = 0;
        sync       = 1'b1;
        for (int c = 1; c <= 80; c++) begin
            @(negedge clk);
            sync       = (c == 5);    // ignored while busy
            cpu_wr     = (c == 10);   // dropped while busy
            cpu_region = REGION_TILE;
            cpu_addr   = 6'd3;
            cpu_wrdata = lost;
            if (done === 1'b1) begin
                done_count++;
                if (done_count == 1) begin
                    check_latency(TILE_DEPTH / 2 + 2, c);
                end
            end
        end
        if (done_count != 1) begin
            $display("ERROR: expected exactly one done during the copy, saw %0d", done_count);
            errors++;
        end
        check_bit("busy", 1'b0, busy);
        tile_ppu = tile_cpu;
        pal_ppu  = pal_cpu;
        do_sync();
        read_all_check();
    endtask

    task automatic random_fill_and_sync();
        int rnd;
        for (int a = 0; a < TILE_DEPTH; a++) begin
            rnd = $random(seed);
            cpu_write(REGION_TILE, a, rnd[15:0]);
        end
        for (int a = 0; a < PAL_DEPTH; a++) begin
            rnd = $random(seed);
            cpu_write(REGION_PAL, a, rnd[15:0]);
        end
        do_sync();
        read_all_check();
    endtask

    initial begin
        errors     = 0;
        seed       = 79439;
        rst_n      = 1'b0;
        sync       = 1'b0;
        cpu_wr     = 1'b0;
        cpu_region = REGION_TILE;
        cpu_addr   = '0;
        cpu_wrdata = '0;
        ppu_region = REGION_TILE;
        ppu_addr   = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        fill_and_sync();
        read_all_check();
        overwrite_without_sync();
        sync_during_copy();
        random_fill_and_sync();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_vram_sync

// File: all.f
rtl/vram_pkg.sv
rtl/vram_if.sv
rtl/vram_dp_ram.sv
rtl/region_copier.sv
rtl/vram_bank.sv
rtl/vram_sync_ctrl.sv
rtl/vram_sync_top.sv
verif/tb_vram_sync.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the VRAM sync testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_vram_sync -f all.f -o tb_vram_sync_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_vram_sync_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
